/* src/icache_pkg.sv */
package icache_pkg;

    // cache geometry
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;
    localparam int LINE_W   = 8 << OFFSET_W;
    localparam int SETS     = 1 << INDEX_W;

    // burst length codes, beats minus one
    localparam logic [7:0] MEM_LEN_LINE     = 8'd15;
    localparam logic [7:0] MEM_LEN_UNCACHED = 8'd1;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // fetch address split into its cache fields
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [2:0]         pair;
        logic [2:0]         low;
    } fetch_addr_t;

    // two instructions per fetch, inst0 at the lower address
    typedef struct packed {
        logic [31:0] inst1;
        logic [31:0] inst0;
    } fetch_pair_t;

    // one cache line
    // raw view for the memory beat, pair view for the fetch select
    typedef union packed {
        logic [LINE_W-1:0]     raw;
        fetch_pair_t [7:0]     pairs;
    } line_u;

    // cache operation codes
    typedef enum logic [1:0] {
        CACOP_STORE_TAG = 2'b00,
        CACOP_INDEX_INV = 2'b01,
        CACOP_HIT_INV   = 2'b10
    } cacop_e;

    // one-hot way mask, bit 0 is way 0
    typedef logic [1:0] way_sel_t;

endpackage

/* src/icache_way.sv */
`timescale 1ns/100ps

module icache_way import icache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    // lookup side
    input  logic [INDEX_W-1:0] i_rd_index,
    input  logic [TAG_W-1:0]   i_tag,
    input  logic [2:0]         i_pair_sel,
    // refill and invalidate side
    input  logic [INDEX_W-1:0] i_wr_index,
    input  logic               i_wr_en,
    input  logic               i_inv_en,
    input  line_u              i_wr_line,
    // lookup result
    output logic               o_hit,
    output fetch_pair_t        o_pair,
    output logic               o_tag_valid
);

    // line and tag storage
    line_u            line_mem [SETS];
    logic [TAG_W-1:0] tag_mem  [SETS];

    // valid bits live in flops so reset can clear them
    logic [SETS-1:0]  valid_q;

    // synchronous read outputs
    line_u            line_rd;
    logic [TAG_W-1:0] tag_rd;
    logic             valid_rd;

    // refill write
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_mem[i_wr_index] <= i_wr_line;
            tag_mem[i_wr_index]  <= i_tag;
        end
    end

    // read one cycle ahead of the compare
    always_ff @(posedge clk) begin
        line_rd <= line_mem[i_rd_index];
        tag_rd  <= tag_mem[i_rd_index];
    end

    // valid bits, invalidate wins over a write to the same set
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q  <= '0;
            valid_rd <= 1'b0;
        end else begin
            if (i_inv_en) begin
                valid_q[i_wr_index] <= 1'b0;
            end else if (i_wr_en) begin
                valid_q[i_wr_index] <= 1'b1;
            end
            valid_rd <= valid_q[i_rd_index];
        end
    end

    assign o_tag_valid = valid_rd;

    // i_tag comes from the registered request, so it lines up with tag_rd
    assign o_hit = valid_rd && (tag_rd == i_tag);

    // pick the requested 8 bytes out of the line
    assign o_pair = line_rd.pairs[i_pair_sel];

endmodule

/* src/icache_lru.sv */
`timescale 1ns/100ps

module icache_lru import icache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_touch,
    input  way_sel_t           i_touch_way,
    output way_sel_t           o_victim
);

    // one bit per set, 1 means way 1 was used last
    logic [SETS-1:0]    mru_q;

    // index registered alongside the way arrays
    logic [INDEX_W-1:0] index_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru_q   <= '0;
            index_q <= '0;
        end else begin
            index_q <= i_index;
            if (i_touch) begin
                mru_q[index_q] <= i_touch_way[1];
            end
        end
    end

    // victim is whichever way was not used last
    assign o_victim = mru_q[index_q] ? 2'b01 : 2'b10;

endmodule

/* src/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl import icache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    // pipeline
    input  logic               i_fetch_valid,
    input  logic [31:0]        i_fetch_pc,
    input  logic               i_uncache,
    output logic               o_fetch_ready,
    output fetch_pair_t        o_fetch_data,
    output logic [31:0]        o_fetch_pc,
    output logic               o_exception,
    input  logic               i_cacop_en,
    input  cacop_e             i_cacop_code,
    input  logic [31:0]        i_cacop_addr,
    output logic               o_cacop_done,
    // main memory
    output logic               o_mem_rvalid,
    input  logic               i_mem_rready,
    output logic [31:0]        o_mem_raddr,
    output logic [7:0]         o_mem_rlen,
    input  line_u              i_mem_rdata,
    // ways
    output logic [INDEX_W-1:0] o_rd_index,
    output logic [TAG_W-1:0]   o_req_tag,
    output logic [2:0]         o_pair_sel,
    output logic [INDEX_W-1:0] o_wr_index,
    output way_sel_t           o_way_wr,
    output way_sel_t           o_way_inv,
    output line_u              o_wr_line,
    input  way_sel_t           i_hit,
    input  fetch_pair_t        i_way_pair0,
    input  fetch_pair_t        i_way_pair1,
    // lru
    output logic               o_lru_touch,
    output way_sel_t           o_lru_way,
    input  way_sel_t           i_victim
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        CACOP
    } state_e;

    state_e      state_q, state_d;

    // request buffer
    fetch_addr_t req_q;
    logic        req_uncache_q;
    logic        req_cacop_q;
    cacop_e      req_code_q;

    // return buffer
    line_u       ret_buf_q;

    fetch_addr_t new_addr;
    logic        misaligned;
    logic        lookup_hit;
    logic        accept;
    logic        refill_fetch;
    logic        refill_alloc;

    // cacop takes priority over a fetch in the same cycle
    assign new_addr = i_cacop_en ? i_cacop_addr : i_fetch_pc;

    assign misaligned = (req_q.low[1:0] != 2'b00);

    // uncached requests never hit, they always go out to memory
    assign lookup_hit = (state_q == LOOKUP) && !misaligned && !req_uncache_q && (|i_hit);

    assign accept = ((state_q == IDLE) || lookup_hit) && (i_fetch_valid || i_cacop_en);

    assign refill_fetch = (state_q == REFILL) && !req_cacop_q;
    assign refill_alloc = refill_fetch && !req_uncache_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = i_cacop_en ? CACOP : LOOKUP;
                end
            end
            LOOKUP: begin
                if (misaligned) begin
                    state_d = IDLE;
                end else if (lookup_hit) begin
                    if (accept) begin
                        state_d = i_cacop_en ? CACOP : LOOKUP;
                    end else begin
                        state_d = IDLE;
                    end
                end else begin
                    state_d = MISS;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    state_d = REFILL;
                end
            end
            // cacop also finishes through REFILL, with no write
            CACOP:   state_d = REFILL;
            REFILL:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q       <= IDLE;
            req_uncache_q <= 1'b0;
            req_cacop_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                req_uncache_q <= i_uncache && !i_cacop_en;
                req_cacop_q   <= i_cacop_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q      <= new_addr;
            req_code_q <= i_cacop_code;
        end
        if ((state_q == MISS) && i_mem_rready) begin
            ret_buf_q <= i_mem_rdata;
        end
    end

    // read the next set as soon as a request is taken
    assign o_rd_index = accept ? new_addr.index : req_q.index;
    assign o_req_tag  = req_q.tag;
    assign o_pair_sel = req_q.pair;
    assign o_wr_index = req_q.index;
    assign o_wr_line  = ret_buf_q;
    assign o_way_wr   = refill_alloc ? i_victim : 2'b00;

    assign o_lru_touch = lookup_hit || refill_alloc;
    assign o_lru_way   = lookup_hit ? i_hit : i_victim;

    // store-tag behaves as index-invalidate, addr bit 0 picks the way
    always_comb begin
        o_way_inv = 2'b00;
        if (state_q == CACOP) begin
            case (req_code_q)
                CACOP_STORE_TAG,
                CACOP_INDEX_INV: o_way_inv = req_q.low[0] ? 2'b10 : 2'b01;
                CACOP_HIT_INV:   o_way_inv = i_hit;
                default:         o_way_inv = 2'b00;
            endcase
        end
    end

    // memory request, line aligned or 8-byte aligned
    assign o_mem_rvalid = (state_q == MISS);
    assign o_mem_raddr  = req_uncache_q ? {req_q[31:3], 3'b000}
                                        : {req_q.tag, req_q.index, {OFFSET_W{1'b0}}};
    assign o_mem_rlen   = req_uncache_q ? MEM_LEN_UNCACHED : MEM_LEN_LINE;

    // pipeline results
    assign o_fetch_ready = ((state_q == LOOKUP) && (misaligned || lookup_hit)) || refill_fetch;
    assign o_exception   = (state_q == LOOKUP) && misaligned;
    assign o_fetch_pc    = req_q;
    assign o_cacop_done  = (state_q == REFILL) && req_cacop_q;

    always_comb begin
        if (o_exception) begin
            o_fetch_data = '{inst1: INST_NOP, inst0: INST_NOP};
        end else if (state_q == REFILL) begin
            // uncached data sits in pair 0 of the beat
            o_fetch_data = req_uncache_q ? ret_buf_q.pairs[0] : ret_buf_q.pairs[req_q.pair];
        end else begin
            o_fetch_data = i_hit[1] ? i_way_pair1 : i_way_pair0;
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    // pipeline
    input  logic        i_fetch_valid,
    input  logic [31:0] i_fetch_pc,
    input  logic        i_uncache,
    output logic        o_fetch_ready,
    output fetch_pair_t o_fetch_data,
    output logic [31:0] o_fetch_pc,
    output logic        o_exception,
    input  logic        i_cacop_en,
    input  cacop_e      i_cacop_code,
    input  logic [31:0] i_cacop_addr,
    output logic        o_cacop_done,
    // main memory
    output logic        o_mem_rvalid,
    input  logic        i_mem_rready,
    output logic [31:0] o_mem_raddr,
    output logic [7:0]  o_mem_rlen,
    input  line_u       i_mem_rdata
);

    logic [INDEX_W-1:0] rd_index;
    logic [TAG_W-1:0]   req_tag;
    logic [2:0]         pair_sel;
    logic [INDEX_W-1:0] wr_index;
    way_sel_t           way_wr;
    way_sel_t           way_inv;
    line_u              wr_line;
    way_sel_t           way_hit;
    fetch_pair_t        way_pair0;
    fetch_pair_t        way_pair1;
    logic               lru_touch;
    way_sel_t           lru_way;
    way_sel_t           victim;

    icache_ctrl ctrl_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_pc    (i_fetch_pc),
        .i_uncache     (i_uncache),
        .o_fetch_ready (o_fetch_ready),
        .o_fetch_data  (o_fetch_data),
        .o_fetch_pc    (o_fetch_pc),
        .o_exception   (o_exception),
        .i_cacop_en    (i_cacop_en),
        .i_cacop_code  (i_cacop_code),
        .i_cacop_addr  (i_cacop_addr),
        .o_cacop_done  (o_cacop_done),
        .o_mem_rvalid  (o_mem_rvalid),
        .i_mem_rready  (i_mem_rready),
        .o_mem_raddr   (o_mem_raddr),
        .o_mem_rlen    (o_mem_rlen),
        .i_mem_rdata   (i_mem_rdata),
        .o_rd_index    (rd_index),
        .o_req_tag     (req_tag),
        .o_pair_sel    (pair_sel),
        .o_wr_index    (wr_index),
        .o_way_wr      (way_wr),
        .o_way_inv     (way_inv),
        .o_wr_line     (wr_line),
        .i_hit         (way_hit),
        .i_way_pair0   (way_pair0),
        .i_way_pair1   (way_pair1),
        .o_lru_touch   (lru_touch),
        .o_lru_way     (lru_way),
        .i_victim      (victim)
    );

    // way 0
    icache_way way0_inst (
        .clk         (clk),
        .rstn        (rstn),
        .i_rd_index  (rd_index),
        .i_tag       (req_tag),
        .i_pair_sel  (pair_sel),
        .i_wr_index  (wr_index),
        .i_wr_en     (way_wr[0]),
        .i_inv_en    (way_inv[0]),
        .i_wr_line   (wr_line),
        .o_hit       (way_hit[0]),
        .o_pair      (way_pair0),
        .o_tag_valid ()
    );

    // way 1
    icache_way way1_inst (
        .clk         (clk),
        .rstn        (rstn),
        .i_rd_index  (rd_index),
        .i_tag       (req_tag),
        .i_pair_sel  (pair_sel),
        .i_wr_index  (wr_index),
        .i_wr_en     (way_wr[1]),
        .i_inv_en    (way_inv[1]),
        .i_wr_line   (wr_line),
        .o_hit       (way_hit[1]),
        .o_pair      (way_pair1),
        .o_tag_valid ()
    );

    icache_lru lru_inst (
        .clk         (clk),
        .rstn        (rstn),
        .i_index     (rd_index),
        .i_touch     (lru_touch),
        .i_touch_way (lru_way),
        .o_victim    (victim)
    );

endmodule

/* testbench/icache_mem_model.sv */
`timescale 1ns/100ps

module icache_mem_model import icache_pkg::*; (
    input  logic        clk,
    input  logic        i_mem_rvalid,
    input  logic [31:0] i_mem_raddr,
    input  logic [7:0]  i_mem_rlen,
    output logic        o_mem_rready,
    output line_u       o_mem_rdata
);

    integer seed;
    int     delay;

    // each 32-bit word is its own byte address xor a fixed pattern
    function automatic line_u build_beat(input logic [31:0] addr, input logic [7:0] len);
        line_u beat;
        int    w;
        beat = '0;
        for (w = 0; w <= int'(len); w++) begin
            beat.raw[w*32 +: 32] = (addr + 32'(4 * w)) ^ 32'h5a5a_0000;
        end
        return beat;
    endfunction

    initial begin
        seed         = 32'ha290;
        o_mem_rready = 1'b0;
        o_mem_rdata  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (i_mem_rvalid) begin
                // random response delay of 0 to 7 cycles
                delay = $random(seed) & 7;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                o_mem_rready = 1'b1;
                o_mem_rdata  = build_beat(i_mem_raddr, i_mem_rlen);
                @(posedge clk);
                #1;
                o_mem_rready = 1'b0;
            end
        end
    end

endmodule

/* testbench/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

    localparam int NUM_ENTRIES    = 24;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40;
    localparam int RESET_CYCLES   = 16;

    typedef enum logic {
        OP_FETCH,
        OP_CACOP
    } op_e;

    // one row of the stimulus table
    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic        uncache;
        cacop_e      code;
        logic        exp_miss;
        logic        exp_exc;
    } stim_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic        i_fetch_valid;
    logic [31:0] i_fetch_pc;
    logic        i_uncache;
    logic        o_fetch_ready;
    fetch_pair_t o_fetch_data;
    logic [31:0] o_fetch_pc;
    logic        o_exception;
    logic        i_cacop_en;
    cacop_e      i_cacop_code;
    logic [31:0] i_cacop_addr;
    logic        o_cacop_done;
    logic        o_mem_rvalid;
    logic        i_mem_rready;
    logic [31:0] o_mem_raddr;
    logic [7:0]  o_mem_rlen;
    line_u       i_mem_rdata;

    stim_t       stim_table [NUM_ENTRIES];
    int          num_loaded;
    int          mem_requests;
    logic [31:0] req_addr_seen;
    logic [7:0]  req_len_seen;
    logic        rvalid_prev = 1'b0;
    int          cycle_count = 0;

    always #2 clk = ~clk;

    icache_top icache_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_pc    (i_fetch_pc),
        .i_uncache     (i_uncache),
        .o_fetch_ready (o_fetch_ready),
        .o_fetch_data  (o_fetch_data),
        .o_fetch_pc    (o_fetch_pc),
        .o_exception   (o_exception),
        .i_cacop_en    (i_cacop_en),
        .i_cacop_code  (i_cacop_code),
        .i_cacop_addr  (i_cacop_addr),
        .o_cacop_done  (o_cacop_done),
        .o_mem_rvalid  (o_mem_rvalid),
        .i_mem_rready  (i_mem_rready),
        .o_mem_raddr   (o_mem_raddr),
        .o_mem_rlen    (o_mem_rlen),
        .i_mem_rdata   (i_mem_rdata)
    );

    icache_mem_model mem_model_inst (
        .clk          (clk),
        .i_mem_rvalid (o_mem_rvalid),
        .i_mem_raddr  (o_mem_raddr),
        .i_mem_rlen   (o_mem_rlen),
        .o_mem_rready (i_mem_rready),
        .o_mem_rdata  (i_mem_rdata)
    );

    // a rising o_mem_rvalid marks one memory request
    always @(negedge clk) begin
        if (o_mem_rvalid && !rvalid_prev) begin
            mem_requests  = mem_requests + 1;
            req_addr_seen = o_mem_raddr;
            req_len_seen  = o_mem_rlen;
        end
        rvalid_prev = o_mem_rvalid;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic report_failure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // two words at the 8-byte aligned address, or two nops on an exception
    function automatic fetch_pair_t expected_pair(input logic [31:0] pc, input logic exc);
        fetch_pair_t p;
        logic [31:0] base;
        base = {pc[31:3], 3'b000};
        if (exc) begin
            p.inst0 = INST_NOP;
            p.inst1 = INST_NOP;
        end else begin
            p.inst0 = base ^ 32'h5a5a_0000;
            p.inst1 = (base + 32'd4) ^ 32'h5a5a_0000;
        end
        return p;
    endfunction

    task automatic check_fetch(input fetch_pair_t got, input fetch_pair_t exp,
                               input logic got_exc, input logic exp_exc,
                               input logic [31:0] got_pc, input logic [31:0] pc);
        if (got_exc !== exp_exc) begin
            report_failure($sformatf("pc %h exception %b, expected %b", pc, got_exc, exp_exc));
        end else if (got_pc !== pc) begin
            report_failure($sformatf("pc %h returned with pc %h", pc, got_pc));
        end else if (got !== exp) begin
            report_failure($sformatf("pc %h data %h_%h, expected %h_%h", pc,
                                     got.inst1, got.inst0, exp.inst1, exp.inst0));
        end
    endtask

    task automatic check_miss(input logic got, input logic exp, input logic [31:0] addr);
        if (got !== exp) begin
            report_failure($sformatf("addr %h memory request %b, expected %b", addr, got, exp));
        end
    endtask

    // line requests are 64-byte aligned, uncached ones 8-byte aligned
    task automatic check_mem_req(input logic [31:0] got_addr, input logic [7:0] got_len,
                                 input logic [31:0] addr, input logic uncache);
        logic [31:0] exp_addr;
        logic [7:0]  exp_len;
        exp_addr = uncache ? {addr[31:3], 3'b000} : {addr[31:6], 6'b00_0000};
        exp_len  = uncache ? MEM_LEN_UNCACHED : MEM_LEN_LINE;
        if (got_addr !== exp_addr) begin
            report_failure($sformatf("addr %h memory address %h, expected %h",
                                     addr, got_addr, exp_addr));
        end else if (got_len !== exp_len) begin
            report_failure($sformatf("addr %h memory length %0d, expected %0d",
                                     addr, got_len, exp_len));
        end
    endtask

    task automatic add_fetch_entry(input logic [31:0] addr, input logic uncache,
                                   input logic miss, input logic exc);
        stim_t s;
        s.op       = OP_FETCH;
        s.addr     = addr;
        s.uncache  = uncache;
        s.code     = CACOP_STORE_TAG;
        s.exp_miss = miss;
        s.exp_exc  = exc;
        if (num_loaded < NUM_ENTRIES) begin
            stim_table[num_loaded] = s;
        end
        num_loaded = num_loaded + 1;
    endtask

    task automatic add_cacop_entry(input cacop_e code, input logic [31:0] addr);
        stim_t s;
        s.op       = OP_CACOP;
        s.addr     = addr;
        s.uncache  = 1'b0;
        s.code     = code;
        s.exp_miss = 1'b0;
        s.exp_exc  = 1'b0;
        if (num_loaded < NUM_ENTRIES) begin
            stim_table[num_loaded] = s;
        end
        num_loaded = num_loaded + 1;
    endtask

    // way placement noted per line, cold sets pick way 1 first
    task automatic load_table();
        add_fetch_entry(32'h0000_0100, 1'b0, 1'b1, 1'b0);  // set 4, way 1
        add_fetch_entry(32'h0000_0100, 1'b0, 1'b0, 1'b0);
        add_fetch_entry(32'h0000_0128, 1'b0, 1'b0, 1'b0);
        // A, B and C all in set 1
        add_fetch_entry(32'h0001_0040, 1'b0, 1'b1, 1'b0);  // A to way 1
        add_fetch_entry(32'h0002_0048, 1'b0, 1'b1, 1'b0);  // B to way 0
        add_fetch_entry(32'h0001_0050, 1'b0, 1'b0, 1'b0);
        add_fetch_entry(32'h0003_0058, 1'b0, 1'b1, 1'b0);  // C evicts B
        add_fetch_entry(32'h0001_0078, 1'b0, 1'b0, 1'b0);
        add_fetch_entry(32'h0002_0040, 1'b0, 1'b1, 1'b0);  // B evicts C
        // uncached never allocates
        add_fetch_entry(32'h0000_0204, 1'b1, 1'b1, 1'b0);
        add_fetch_entry(32'h0000_0204, 1'b1, 1'b1, 1'b0);
        add_fetch_entry(32'h0000_0200, 1'b0, 1'b1, 1'b0);
        // misaligned pc
        add_fetch_entry(32'h0000_0102, 1'b0, 1'b0, 1'b1);
        add_fetch_entry(32'h0000_0203, 1'b1, 1'b0, 1'b1);
        add_fetch_entry(32'h0000_0100, 1'b0, 1'b0, 1'b0);
        add_cacop_entry(CACOP_HIT_INV, 32'h0000_0100);
        add_fetch_entry(32'h0000_0100, 1'b0, 1'b1, 1'b0);  // refill to way 0
        // set 1 now holds A in way 1 and B in way 0
        add_cacop_entry(CACOP_INDEX_INV, 32'h0000_0041);
        add_fetch_entry(32'h0001_0040, 1'b0, 1'b1, 1'b0);
        add_fetch_entry(32'h0002_0040, 1'b0, 1'b0, 1'b0);
        add_cacop_entry(CACOP_STORE_TAG, 32'h0000_0040);   // clears B in way 0
        add_fetch_entry(32'h0002_0060, 1'b0, 1'b1, 1'b0);  // B evicts A from way 1
        add_fetch_entry(32'h0001_0040, 1'b0, 1'b1, 1'b0);  // A to way 0
        add_fetch_entry(32'h0002_0068, 1'b0, 1'b0, 1'b0);
    endtask

    // one request for a single accepting edge, then wait for its result
    task automatic apply_entry(input stim_t s);
        logic finished;
        @(posedge clk);
        #1;
        mem_requests = 0;
        if (s.op == OP_CACOP) begin
            i_cacop_en   = 1'b1;
            i_cacop_code = s.code;
            i_cacop_addr = s.addr;
        end else begin
            i_fetch_valid = 1'b1;
            i_fetch_pc    = s.addr;
            i_uncache     = s.uncache;
        end
        @(posedge clk);
        #1;
        i_fetch_valid = 1'b0;
        i_cacop_en    = 1'b0;
        finished      = 1'b0;
        while (!finished) begin
            @(negedge clk);
            finished = (s.op == OP_CACOP) ? o_cacop_done : o_fetch_ready;
        end
        if (s.op == OP_FETCH) begin
            check_fetch(o_fetch_data, expected_pair(s.addr, s.exp_exc),
                        o_exception, s.exp_exc, o_fetch_pc, s.addr);
        end
        check_miss(mem_requests != 0, s.exp_miss, s.addr);
        if (s.exp_miss) begin
            check_mem_req(req_addr_seen, req_len_seen, s.addr, s.uncache);
        end
    endtask

    initial begin
        int idx;
        rstn          = 1'b0;
        i_fetch_valid = 1'b0;
        i_fetch_pc    = '0;
        i_uncache     = 1'b0;
        i_cacop_en    = 1'b0;
        i_cacop_code  = CACOP_STORE_TAG;
        i_cacop_addr  = '0;
        num_loaded    = 0;
        mem_requests  = 0;
        req_addr_seen = '0;
        req_len_seen  = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            apply_entry(stim_table[idx]);
        end
        if (num_loaded == NUM_ENTRIES) begin
            $display("Simulation PASSED");
        end else begin
            $display("table loaded %0d entries but %0d were expected", num_loaded, NUM_ENTRIES);
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* icache.f */
src/icache_pkg.sv
src/icache_way.sv
src/icache_lru.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv
